/* raytracer.f */
+incdir+include
hw/raytrace_pkg.sv
hw/raytrace_if.sv
hw/scene_regs.sv
hw/card_caster.sv
hw/raytrace_ctrl.sv
hw/raytracer_top.sv
sim/raytracer_asserts.sv
sim/raytracer_tb.sv

/* Makefile */
# Verilator build and run for the ray caster testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module raytracer_tb \
		-f raytracer.f -o raytracer_sim

run: compile
	@out=$$(./obj_dir/raytracer_sim); status=$$?; echo "$$out"; \
		echo "$$out" | grep -q "All checks passed" || exit 1; exit $$status

clean:
	rm -rf obj_dir

/* sim/raytracer_tb.sv */
`timescale 1ns/1ps
`include "raytrace_cfg.svh"

module raytracer_tb;
    import raytrace_pkg::*;

    localparam int     NUM_PIX       = `SCREEN_W * `SCREEN_H;
    localparam int     NUM_FRAMES    = 5;
    localparam int     AXI_TIMEOUT   = 100;
    localparam int     FRAME_TIMEOUT = NUM_PIX * 2 * (`NUM_CARDS + 3) * 4;
    localparam longint WATCHDOG_NS   = (longint'(NUM_FRAMES) * NUM_PIX * 2 * (`NUM_CARDS + 3)
                                        + 5000) * 100;

    logic                   clk;
    logic                   rst;
    logic [`AXI_ADDR_W-1:0] awaddr;
    logic                   awvalid;
    logic                   awready;
    logic [31:0]            wdata;
    logic                   wvalid;
    logic                   wready;
    logic [1:0]             bresp;
    logic                   bvalid;
    logic                   bready;
    logic [`AXI_ADDR_W-1:0] araddr;
    logic                   arvalid;
    logic                   arready;
    logic [31:0]            rdata;
    logic [1:0]             rresp;
    logic                   rvalid;
    logic                   rready;
    logic                   pix_valid;
    logic                   pix_ready;
    pix_x_t                 pix_x;
    pix_y_t                 pix_y;
    color_t                 pix_color;
    logic                   pix_last;

    // testbench copy of the scene
    int scene_x0 [`NUM_CARDS];
    int scene_y0 [`NUM_CARDS];
    int scene_x1 [`NUM_CARDS];
    int scene_y1 [`NUM_CARDS];
    int scene_z [`NUM_CARDS];
    int scene_color [`NUM_CARDS];
    bit scene_en [`NUM_CARDS];
    int scene_bg;
    int scene_sx;
    int scene_sy;

    integer seed = 1;
    bit     random_ready = 1'b0;
    bit     run_passed = 1'b0;
    bit     fail_shown = 1'b0;
    string  test_name = "reset";
    int     frame_pix = 0;
    int     frames_done = 0;
    int     total_pixels = 0;
    int     exp_x;
    int     exp_y;

    raytracer_top i_dut (.*);

    always #50 clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        fail_shown = 1'b1;
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual)
            fail_run($sformatf("Fail %s: expected %0h, actual %0h", name, expected, actual));
    endtask

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
        int waited;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        waited  = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > AXI_TIMEOUT)
                fail_run("AXI write was never accepted");
        end while (!awready);
        check({test_name, " wready"}, 32'd1, 32'(wready));
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        waited  = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > AXI_TIMEOUT)
                fail_run("AXI write response never arrived");
        end while (!bvalid);
        check({test_name, " bresp"}, 32'd0, 32'(bresp));
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
        int waited;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        waited  = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > AXI_TIMEOUT)
                fail_run("AXI read address was never accepted");
        end while (!arready);
        @(negedge clk);
        arvalid = 1'b0;
        waited  = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > AXI_TIMEOUT)
                fail_run("AXI read data never arrived");
        end while (!rvalid);
        data = rdata;
        check({test_name, " rresp"}, 32'd0, 32'(rresp));
        @(negedge clk);
        rready = 1'b0;
    endtask

    function automatic logic [7:0] card_addr(input int k, input int word);
        return 8'(`REG_CARD_BASE + `CARD_STRIDE * k + 4 * word);
    endfunction

    task automatic set_card(input int k, input int x0, input int y0, input int x1,
                            input int y1, input int z, input bit en, input int color);
        scene_x0[k]    = x0;
        scene_y0[k]    = y0;
        scene_x1[k]    = x1;
        scene_y1[k]    = y1;
        scene_z[k]     = z;
        scene_en[k]    = en;
        scene_color[k] = color;
        axi_write(card_addr(k, 0), {16'b0, 8'(y0), 8'(x0)});
        axi_write(card_addr(k, 1), {16'b0, 8'(y1), 8'(x1)});
        axi_write(card_addr(k, 2), {en, 23'b0, 8'(z)});
        axi_write(card_addr(k, 3), {16'b0, 16'(color)});
    endtask

    task automatic set_light(input int sx, input int sy);
        scene_sx = sx;
        scene_sy = sy;
        axi_write(8'(`REG_LIGHT), {24'b0, 4'(sy), 4'(sx)});
    endtask

    // nearest card along -z and then occluders toward the light
    function automatic color_t render_pixel(input int x, input int y);
        int best;
        int dz;
        int px;
        int py;
        int k;
        bit blocked;
        best    = -1;
        blocked = 1'b0;
        for (k = 0; k < `NUM_CARDS; k++) begin
            if (scene_en[k] && x >= scene_x0[k] && x <= scene_x1[k] &&
                y >= scene_y0[k] && y <= scene_y1[k]) begin
                if (best < 0 || scene_z[k] > scene_z[best])
                    best = k;   // ties keep the lower index
            end
        end
        if (best < 0)
            return color_t'(scene_bg);
        for (k = 0; k < `NUM_CARDS; k++) begin
            if (scene_en[k] && scene_z[k] > scene_z[best]) begin
                dz = scene_z[k] - scene_z[best];
                px = x + scene_sx * dz;
                py = y + scene_sy * dz;
                if (px >= scene_x0[k] && px <= scene_x1[k] &&
                    py >= scene_y0[k] && py <= scene_y1[k])
                    blocked = 1'b1;
            end
        end
        return blocked ? color_t'(0) : color_t'(scene_color[best]);
    endfunction

    task automatic run_frame(input string name, input bit restart);
        logic [31:0] rd;
        int          start_frames;
        int          start_pixels;
        int          waited;
        test_name    = name;
        start_frames = frames_done;
        start_pixels = total_pixels;
        axi_write(8'(`REG_CTRL), 32'd1);
        axi_read(8'(`REG_STATUS), rd);
        check({name, " status busy"}, 32'd1, rd);
        if (restart)
            axi_write(8'(`REG_CTRL), 32'd1);   // lands mid-frame
        waited = 0;
        while (frames_done == start_frames) begin
            @(negedge clk);
            waited++;
            if (waited > FRAME_TIMEOUT)
                fail_run({name, ": frame did not finish"});
        end
        axi_read(8'(`REG_STATUS), rd);
        check({name, " status idle"}, 32'd0, rd);
        if (restart) begin
            repeat (40) @(negedge clk);
            check({name, " pixel count"}, 32'(start_pixels + NUM_PIX), 32'(total_pixels));
        end
    endtask

    // pixel stream stimulus
    always @(negedge clk) begin
        if (random_ready)
            pix_ready <= (($random(seed) & 3) != 0);
        else
            pix_ready <= 1'b1;
    end

    // checks every pixel handshake against the reference
    always @(posedge clk) begin
        if (!rst && pix_valid && pix_ready) begin
            exp_x = frame_pix % `SCREEN_W;
            exp_y = frame_pix / `SCREEN_W;
            check({test_name, " pix_x"}, 32'(exp_x), 32'(pix_x));
            check({test_name, " pix_y"}, 32'(exp_y), 32'(pix_y));
            check({test_name, " pix_color"}, 32'(render_pixel(exp_x, exp_y)), 32'(pix_color));
            check({test_name, " pix_last"}, 32'(frame_pix == NUM_PIX - 1), 32'(pix_last));
            total_pixels++;
            if (pix_last) begin
                frame_pix = 0;
                frames_done++;
            end else begin
                frame_pix++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run("watchdog expired before the tests finished");
    end

    initial begin
        logic [31:0] rd;
        int          k;
        clk       = 1'b0;
        rst       = 1'b1;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        pix_ready = 1'b0;
        scene_bg  = 0;
        scene_sx  = 0;
        scene_sy  = 0;
        for (k = 0; k < `NUM_CARDS; k++)
            scene_en[k] = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        test_name = "registers";
        for (k = 0; k < `NUM_CARDS; k++)
            set_card(k, k, k + 1, k + 4, k + 3, 16 * k + 1, 1'b0, 'h0101 * k + 'h20);
        for (k = 0; k < `NUM_CARDS; k++) begin
            axi_read(card_addr(k, 0), rd);
            check("registers card word 0", {16'b0, 8'(scene_y0[k]), 8'(scene_x0[k])}, rd);
            axi_read(card_addr(k, 1), rd);
            check("registers card word 1", {16'b0, 8'(scene_y1[k]), 8'(scene_x1[k])}, rd);
            axi_read(card_addr(k, 2), rd);
            check("registers card word 2", {scene_en[k], 23'b0, 8'(scene_z[k])}, rd);
            axi_read(card_addr(k, 3), rd);
            check("registers card word 3", {16'b0, 16'(scene_color[k])}, rd);
        end
        scene_bg = 'hABCD;
        axi_write(8'(`REG_BG), 32'(scene_bg));
        axi_read(8'(`REG_BG), rd);
        check("registers background", 32'(scene_bg), rd);
        set_light(-3, 5);
        axi_read(8'(`REG_LIGHT), rd);
        check("registers light", {24'b0, 4'(5), 4'(-3)}, rd);
        axi_read(8'h10, rd);
        check("registers unmapped 0x10", 32'd0, rd);
        axi_read(8'h3C, rd);
        check("registers unmapped 0x3c", 32'd0, rd);
        axi_read(8'hC0, rd);
        check("registers unmapped 0xc0", 32'd0, rd);
        axi_read(8'(`REG_STATUS), rd);
        check("registers status", 32'd0, rd);

        run_frame("empty scene", 1'b0);   // every card still disabled

        set_light(0, 0);
        set_card(0, 2, 2, 9, 7, 10, 1'b1, 'hF800);
        set_card(1, 5, 4, 13, 10, 20, 1'b1, 'h07E0);
        set_card(2, 0, 0, 3, 3, 10, 1'b1, 'h001F);   // same depth as card 0
        run_frame("nearest hit", 1'b0);

        set_card(0, 0, 0, 0, 0, 0, 1'b0, 0);
        set_card(1, 0, 0, 0, 0, 0, 1'b0, 0);
        set_card(2, 0, 0, 0, 0, 0, 1'b0, 0);
        set_card(3, 0, 0, 15, 11, 5, 1'b1, 'h7BEF);    // ground
        set_card(4, 6, 4, 9, 7, 8, 1'b1, 'hFFE0);      // floating above it
        set_card(5, 12, 0, 15, 3, 200, 1'b1, 'h1234);  // high above so shadow rays run long
        set_light(2, 1);
        run_frame("shadow positive", 1'b0);
        set_light(-1, -1);
        run_frame("shadow negative", 1'b0);

        random_ready = 1'b1;
        run_frame("back-pressure", 1'b1);
        random_ready = 1'b0;

        if (total_pixels == NUM_FRAMES * NUM_PIX) begin
            run_passed = 1'b1;
            $display("All checks passed");
            $finish;
        end else begin
            fail_run($sformatf("pixel total is %0d, %0d were due", total_pixels,
                               NUM_FRAMES * NUM_PIX));
        end
    end

    final begin
        if (!run_passed && !fail_shown)
            $display("Checks failed");
    end

endmodule

/* sim/raytracer_asserts.sv */
`timescale 1ns/1ps
`include "raytrace_cfg.svh"

module raytracer_asserts (
    input logic                 clk,
    input logic                 rst,
    input logic                 pix_valid,
    input logic                 pix_ready,
    input raytrace_pkg::pix_x_t pix_x,
    input raytrace_pkg::pix_y_t pix_y,
    input raytrace_pkg::color_t pix_color,
    input logic                 pix_last,
    input logic                 awready,
    input logic                 wvalid,
    input logic                 bvalid,
    input logic                 bready,
    input logic                 cast_start,
    input logic                 cast_done
);
    import raytrace_pkg::*;

    // stalled pixel keeps its place and its data
    pix_hold: assert property (@(posedge clk) disable iff (rst)
        pix_valid && !pix_ready |=> pix_valid && $stable(pix_x) && $stable(pix_y) &&
                                    $stable(pix_color) && $stable(pix_last))
        else $error("pixel stream changed while stalled");

    b_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else $error("write response dropped before bready");

    // accepted write answers on the next cycle
    aw_with_w: assert property (@(posedge clk) disable iff (rst)
        awready |-> wvalid ##1 bvalid)
        else $error("write accepted without wvalid or without a response");

    // fixed caster latency
    cast_latency: assert property (@(posedge clk) disable iff (rst)
        cast_start |-> ##(`NUM_CARDS + 1) cast_done)
        else $error("cast done missed its fixed latency");

endmodule

bind raytracer_top raytracer_asserts i_asserts (
    .clk        (clk),
    .rst        (rst),
    .pix_valid  (pix_valid),
    .pix_ready  (pix_ready),
    .pix_x      (pix_x),
    .pix_y      (pix_y),
    .pix_color  (pix_color),
    .pix_last   (pix_last),
    .awready    (awready),
    .wvalid     (wvalid),
    .bvalid     (bvalid),
    .bready     (bready),
    .cast_start (i_cast.start),
    .cast_done  (i_cast.done)
);

/* hw/raytracer_top.sv */
`timescale 1ns/1ps
`include "raytrace_cfg.svh"

module raytracer_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`AXI_ADDR_W-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [31:0]            wdata,
    input  logic                   wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  logic [`AXI_ADDR_W-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [31:0]            rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready,
    output logic                   pix_valid,
    input  logic                   pix_ready,
    output raytrace_pkg::pix_x_t   pix_x,
    output raytrace_pkg::pix_y_t   pix_y,
    output raytrace_pkg::color_t   pix_color,
    output logic                   pix_last
);
    import raytrace_pkg::*;

    cast_if    i_cast ();
    card_rd_if i_card ();

    logic   go;
    logic   busy;
    color_t background;
    slope_t sx;
    slope_t sy;

    scene_regs i_regs (
        .clk        (clk),
        .rst        (rst),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .card       (i_card),
        .go         (go),
        .background (background),
        .sx         (sx),
        .sy         (sy),
        .busy       (busy)
    );

    card_caster i_caster (
        .clk  (clk),
        .rst  (rst),
        .cast (i_cast),
        .card (i_card)
    );

    raytrace_ctrl i_ctrl (
        .clk        (clk),
        .rst        (rst),
        .go         (go),
        .background (background),
        .sx         (sx),
        .sy         (sy),
        .busy       (busy),
        .cast       (i_cast),
        .pix_valid  (pix_valid),
        .pix_ready  (pix_ready),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .pix_color  (pix_color),
        .pix_last   (pix_last)
    );

endmodule

/* hw/raytrace_ctrl.sv */
`timescale 1ns/1ps
`include "raytrace_cfg.svh"

module raytrace_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   go,
    input  raytrace_pkg::color_t   background,
    input  raytrace_pkg::slope_t   sx,
    input  raytrace_pkg::slope_t   sy,
    output logic                   busy,
    cast_if.ctrl                   cast,
    output logic                   pix_valid,
    input  logic                   pix_ready,
    output raytrace_pkg::pix_x_t   pix_x,
    output raytrace_pkg::pix_y_t   pix_y,
    output raytrace_pkg::color_t   pix_color,
    output logic                   pix_last
);
    import raytrace_pkg::*;

    ctrl_state_t state;
    pix_x_t      px;
    pix_y_t      py;
    logic        start_r;
    logic        last_pix;

    // hit record of the primary cast
    coord_t hit_z_r;
    color_t hit_color_r;
    color_t color_r;

    assign last_pix = (px == pix_x_t'(`SCREEN_W - 1)) && (py == pix_y_t'(`SCREEN_H - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            px      <= '0;
            py      <= '0;
            start_r <= 1'b0;
        end else begin
            start_r <= 1'b0;
            case (state)
                IDLE: begin
                    if (go) begin
                        px      <= '0;
                        py      <= '0;
                        start_r <= 1'b1;
                        state   <= PRIMARY;
                    end
                end
                PRIMARY: begin
                    if (cast.done) begin
                        if (cast.hit) begin
                            start_r <= 1'b1;   // shadow cast toward the light
                            state   <= SHADOW;
                        end else begin
                            state <= EMIT;
                        end
                    end
                end
                SHADOW: begin
                    if (cast.done)
                        state <= EMIT;
                end
                EMIT: begin
                    if (pix_ready) begin
                        if (last_pix) begin
                            state <= IDLE;
                        end else begin
                            if (px == pix_x_t'(`SCREEN_W - 1)) begin
                                px <= '0;
                                py <= py + 1'b1;
                            end else begin
                                px <= px + 1'b1;
                            end
                            start_r <= 1'b1;
                            state   <= PRIMARY;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == PRIMARY && cast.done) begin
            hit_z_r     <= cast.hit_z;
            hit_color_r <= cast.hit_color;
            color_r     <= background;   // kept on a miss
        end
        if (state == SHADOW && cast.done)
            color_r <= cast.hit ? color_t'(0) : hit_color_r;   // blocked is black
    end

    assign cast.start  = start_r;
    assign cast.shadow = (state == SHADOW);
    assign cast.ray_x  = coord_t'(px);
    assign cast.ray_y  = coord_t'(py);
    assign cast.ray_z  = hit_z_r;
    assign cast.sx     = sx;
    assign cast.sy     = sy;

    assign busy      = (state != IDLE);
    assign pix_valid = (state == EMIT);
    assign pix_x     = px;
    assign pix_y     = py;
    assign pix_color = color_r;
    assign pix_last  = last_pix;

endmodule

/* hw/card_caster.sv */
`timescale 1ns/1ps
`include "raytrace_cfg.svh"

module card_caster (
    input  logic    clk,
    input  logic    rst,
    cast_if.caster  cast,
    card_rd_if.caster card
);
    import raytrace_pkg::*;

    logic      active;
    logic      done_r;
    card_idx_t idx;

    // ray latched at start, held through the sweep
    logic   shadow_r;
    coord_t ray_x_r;
    coord_t ray_y_r;
    coord_t ray_z_r;
    slope_t sx_r;
    slope_t sy_r;

    logic   best_hit;
    coord_t best_z;
    color_t best_color;
    logic   blocked;   // sticky over the sweep

    coord_t  dz;
    spoint_t dz_ext;
    spoint_t pt_x;
    spoint_t pt_y;
    logic    in_front;
    logic    in_rect;
    logic    card_hit;
    logic    take_best;

    assign card.idx = idx;

    // shadow sample point at the card's depth, signed multiply-add
    assign dz     = card.z - ray_z_r;
    assign dz_ext = spoint_t'(dz);
    assign pt_x   = shadow_r ? spoint_t'(sx_r) * dz_ext + spoint_t'(ray_x_r)
                             : spoint_t'(ray_x_r);
    assign pt_y   = shadow_r ? spoint_t'(sy_r) * dz_ext + spoint_t'(ray_y_r)
                             : spoint_t'(ray_y_r);

    assign in_front = !shadow_r || (card.z > ray_z_r);
    assign in_rect  = (pt_x >= spoint_t'(card.x0)) && (pt_x <= spoint_t'(card.x1)) &&
                      (pt_y >= spoint_t'(card.y0)) && (pt_y <= spoint_t'(card.y1));
    assign card_hit = active && card.en && in_front && in_rect;

    // strictly greater, so an equal depth keeps the lower index
    assign take_best = card_hit && !shadow_r && (!best_hit || card.z > best_z);

    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            done_r   <= 1'b0;
            idx      <= '0;
            best_hit <= 1'b0;
            blocked  <= 1'b0;
        end else begin
            done_r <= 1'b0;
            if (cast.start) begin
                active   <= 1'b1;
                idx      <= '0;
                best_hit <= 1'b0;
                blocked  <= 1'b0;
            end else if (active) begin
                if (take_best)
                    best_hit <= 1'b1;
                if (card_hit && shadow_r)
                    blocked <= 1'b1;
                if (idx == card_idx_t'(`NUM_CARDS - 1)) begin
                    active <= 1'b0;
                    done_r <= 1'b1;   // results ready NUM_CARDS + 1 after start
                end
                idx <= idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cast.start) begin
            shadow_r <= cast.shadow;
            ray_x_r  <= cast.ray_x;
            ray_y_r  <= cast.ray_y;
            ray_z_r  <= cast.ray_z;
            sx_r     <= cast.sx;
            sy_r     <= cast.sy;
        end
        if (take_best) begin
            best_z     <= card.z;
            best_color <= card.color;
        end
    end

    assign cast.done      = done_r;
    assign cast.hit       = shadow_r ? blocked : best_hit;
    assign cast.hit_z     = best_z;
    assign cast.hit_color = best_color;

endmodule

/* hw/scene_regs.sv */
`timescale 1ns/1ps
`include "raytrace_cfg.svh"

module scene_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`AXI_ADDR_W-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [31:0]            wdata,
    input  logic                   wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  logic [`AXI_ADDR_W-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [31:0]            rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready,
    card_rd_if.regs                card,
    output logic                   go,
    output raytrace_pkg::color_t   background,
    output raytrace_pkg::slope_t   sx,
    output raytrace_pkg::slope_t   sy,
    input  logic                   busy
);
    import raytrace_pkg::*;

    localparam int CARD_SHIFT = $clog2(`CARD_STRIDE);
    localparam int CARD_END   = `REG_CARD_BASE + `NUM_CARDS * `CARD_STRIDE;

    // card table
    coord_t card_x0 [`NUM_CARDS];
    coord_t card_y0 [`NUM_CARDS];
    coord_t card_x1 [`NUM_CARDS];
    coord_t card_y1 [`NUM_CARDS];
    coord_t card_z [`NUM_CARDS];
    color_t card_color [`NUM_CARDS];
    logic [`NUM_CARDS-1:0] card_en;

    color_t bg_r;
    slope_t sx_r;
    slope_t sy_r;

    logic                   wr_fire;
    logic                   rd_fire;
    logic                   wr_card;
    logic                   rd_card;
    logic [`AXI_ADDR_W-1:0] wr_off;
    logic [`AXI_ADDR_W-1:0] rd_off;
    card_idx_t              wr_idx;
    card_idx_t              rd_idx;
    logic [1:0]             wr_word;
    logic [1:0]             rd_word;
    logic [31:0]            rd_val;

    // address and data accepted together, one write in flight
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign bresp   = 2'b00;

    assign arready = !rvalid;
    assign rd_fire = arvalid && arready;
    assign rresp   = 2'b00;

    assign wr_card = (awaddr >= `REG_CARD_BASE) && (awaddr < CARD_END);
    assign wr_off  = awaddr - `AXI_ADDR_W'(`REG_CARD_BASE);
    assign wr_idx  = card_idx_t'(wr_off >> CARD_SHIFT);
    assign wr_word = wr_off[CARD_SHIFT-1:2];

    assign rd_card = (araddr >= `REG_CARD_BASE) && (araddr < CARD_END);
    assign rd_off  = araddr - `AXI_ADDR_W'(`REG_CARD_BASE);
    assign rd_idx  = card_idx_t'(rd_off >> CARD_SHIFT);
    assign rd_word = rd_off[CARD_SHIFT-1:2];

    always_comb begin
        rd_val = '0;   // unmapped reads as zero
        if (rd_card) begin
            case (rd_word)
                2'd0:    rd_val = {16'b0, card_y0[rd_idx], card_x0[rd_idx]};
                2'd1:    rd_val = {16'b0, card_y1[rd_idx], card_x1[rd_idx]};
                2'd2:    rd_val = {card_en[rd_idx], 23'b0, card_z[rd_idx]};
                default: rd_val = {16'b0, card_color[rd_idx]};
            endcase
        end else begin
            case (araddr)
                `REG_STATUS: rd_val = {31'b0, busy};
                `REG_BG:     rd_val = {16'b0, bg_r};
                `REG_LIGHT:  rd_val = {24'b0, sy_r, sx_r};
                default:     rd_val = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire && wr_card) begin
            case (wr_word)
                2'd0: begin
                    card_x0[wr_idx] <= wdata[`COORD_W-1:0];
                    card_y0[wr_idx] <= wdata[2*`COORD_W-1:`COORD_W];
                end
                2'd1: begin
                    card_x1[wr_idx] <= wdata[`COORD_W-1:0];
                    card_y1[wr_idx] <= wdata[2*`COORD_W-1:`COORD_W];
                end
                2'd2:    card_z[wr_idx] <= wdata[`COORD_W-1:0];
                default: card_color[wr_idx] <= wdata[15:0];
            endcase
        end
        if (rd_fire)
            rdata <= rd_val;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            card_en <= '0;
            bg_r    <= '0;
            sx_r    <= '0;
            sy_r    <= '0;
            go      <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            go <= wr_fire && (awaddr == `REG_CTRL) && wdata[0] && !busy;  // no restart mid-frame

            if (wr_fire)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;

            if (rd_fire)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;

            if (wr_fire && wr_card && wr_word == 2'd2)
                card_en[wr_idx] <= wdata[31];
            if (wr_fire && awaddr == `REG_BG)
                bg_r <= wdata[15:0];
            if (wr_fire && awaddr == `REG_LIGHT) begin
                sx_r <= wdata[3:0];
                sy_r <= wdata[7:4];
            end
        end
    end

    // caster port, combinational lookup
    assign card.x0    = card_x0[card.idx];
    assign card.y0    = card_y0[card.idx];
    assign card.x1    = card_x1[card.idx];
    assign card.y1    = card_y1[card.idx];
    assign card.z     = card_z[card.idx];
    assign card.en    = card_en[card.idx];
    assign card.color = card_color[card.idx];

    assign background = bg_r;
    assign sx         = sx_r;
    assign sy         = sy_r;

endmodule

/* hw/raytrace_if.sv */
`timescale 1ns/1ps

// controller to caster, one cast per start pulse
interface cast_if;
    import raytrace_pkg::*;

    logic    start;
    logic    shadow;     // 0 primary ray, 1 shadow ray
    coord_t  ray_x;
    coord_t  ray_y;
    coord_t  ray_z;      // depth of the surface for shadow rays
    slope_t  sx;
    slope_t  sy;
    logic    done;
    logic    hit;        // nearest card in primary mode, blocked in shadow mode
    coord_t  hit_z;
    color_t  hit_color;

    modport ctrl   (output start, shadow, ray_x, ray_y, ray_z, sx, sy,
                    input  done, hit, hit_z, hit_color);
    modport caster (input  start, shadow, ray_x, ray_y, ray_z, sx, sy,
                    output done, hit, hit_z, hit_color);
endinterface

// caster reads one card slot per cycle from the register file
interface card_rd_if;
    import raytrace_pkg::*;

    card_idx_t idx;
    coord_t    x0;
    coord_t    y0;
    coord_t    x1;
    coord_t    y1;
    coord_t    z;
    logic      en;
    color_t    color;

    modport caster (output idx, input x0, y0, x1, y1, z, en, color);
    modport regs   (input idx, output x0, y0, x1, y1, z, en, color);
endinterface

/* hw/raytrace_pkg.sv */
`include "raytrace_cfg.svh"

package raytrace_pkg;

    // card and screen coordinate, also used for depth
    typedef logic [`COORD_W-1:0] coord_t;

    // shadow sample point, may fall off screen on either side
    typedef logic signed [`SHADOW_W-1:0] spoint_t;

    // light slope per unit of depth
    typedef logic signed [3:0] slope_t;

    typedef logic [15:0] color_t;   // rgb565

    typedef logic [$clog2(`NUM_CARDS)-1:0] card_idx_t;

    typedef logic [$clog2(`SCREEN_W)-1:0] pix_x_t;
    typedef logic [$clog2(`SCREEN_H)-1:0] pix_y_t;

    // controller FSM
    typedef enum logic [1:0] {
        IDLE,
        PRIMARY,   // nearest card along -z
        SHADOW,    // occluder toward the light
        EMIT       // pixel on the stream
    } ctrl_state_t;

endpackage

/* include/raytrace_cfg.svh */
`ifndef RAYTRACE_CFG_SVH
`define RAYTRACE_CFG_SVH

// frame size in pixels
`define SCREEN_W      16
`define SCREEN_H      12

`define NUM_CARDS     8
`define COORD_W       8
`define SHADOW_W      12   // signed shadow sample, slope * depth + coordinate

// register map
`define AXI_ADDR_W    8
`define REG_CTRL      'h00
`define REG_STATUS    'h04
`define REG_BG        'h08
`define REG_LIGHT     'h0C
`define REG_CARD_BASE 'h40
`define CARD_STRIDE   16

`endif
